// File: design/vdp_pkg.sv
// ------------------------------
// Shared widths, port numbers, status constants
// and the port-1 sequencer states of the VDP register block
// ------------------------------
package vdp_pkg;

  // ------------------------------
  // Widths with a meaning
  // ------------------------------
  typedef logic [7:0]  cpu_byte_t;    // CPU data byte
  typedef logic [1:0]  port_sel_t;    // I/O port 0..3
  typedef logic [5:0]  reg_num_t;     // Control register number
  typedef logic [3:0]  status_num_t;  // Status register number (R15)
  typedef logic [16:0] vram_addr_t;   // 128 KB VRAM address
  typedef logic [2:0]  pal_chan_t;    // One palette colour channel

  // {R0[3:1], R1[3], R1[4]}
  typedef logic [4:0]  disp_mode_t;

  // Port-1 byte pair sequencer
  typedef enum logic {
    P1_FIRST,   // Waiting for data / low address byte
    P1_SECOND   // Waiting for command byte
  } p1_state_e;

  // ------------------------------
  // Port numbers
  // ------------------------------
  localparam port_sel_t PORT_VRAM     = 2'd0;  // VRAM data
  localparam port_sel_t PORT_CTRL     = 2'd1;  // Status read, address / register set
  localparam port_sel_t PORT_PALETTE  = 2'd2;  // Palette byte pairs
  localparam port_sel_t PORT_INDIRECT = 2'd3;  // Register write through R17

  // ------------------------------
  // Fixed values
  // ------------------------------
  localparam logic [4:0] VDP_ID      = 5'd2;     // V9958 identity in S#1
  localparam reg_num_t   REG_R17_NUM = 6'd17;    // Not writable through port 3
  localparam cpu_byte_t  STATUS_FILL = 8'hFF;    // Unimplemented status reads

endpackage

// File: design/vdp_palette_ram.sv
// ------------------------------
// Three-channel palette memory,
// MSX2 default colours, registered read
// ------------------------------
`timescale 1ns/1ps

module vdp_palette_ram #(
  parameter int PAL_ENTRIES = 16
) (
  input  logic                           RESET,    // Clock
  input  logic                           CLK21M,   // Async reset
  input  logic                           pal_we,
  input  logic [$clog2(PAL_ENTRIES)-1:0] pal_wr_idx,
  input  vdp_pkg::pal_chan_t             pal_wr_r, pal_wr_g, pal_wr_b,
  input  logic [$clog2(PAL_ENTRIES)-1:0] pal_rd_idx,
  output vdp_pkg::pal_chan_t             pal_r, pal_g, pal_b
);
  import vdp_pkg::*;

  // Standard MSX2 colours 0..15
  localparam pal_chan_t DEF_R [16] = '{0, 0, 1, 3, 1, 2, 5, 2, 7, 7, 6, 6, 1, 6, 5, 7};
  localparam pal_chan_t DEF_G [16] = '{0, 0, 6, 7, 1, 3, 1, 6, 1, 3, 6, 6, 4, 2, 5, 7};
  localparam pal_chan_t DEF_B [16] = '{0, 0, 1, 3, 7, 7, 1, 7, 1, 3, 1, 4, 1, 5, 5, 7};

  pal_chan_t mem_r [PAL_ENTRIES];
  pal_chan_t mem_g [PAL_ENTRIES];
  pal_chan_t mem_b [PAL_ENTRIES];

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      for (int i = 0; i < PAL_ENTRIES; i++) begin
        mem_r[i] <= DEF_R[i % 16];
        mem_g[i] <= DEF_G[i % 16];
        mem_b[i] <= DEF_B[i % 16];
      end
    end else if (pal_we) begin
      mem_r[pal_wr_idx] <= pal_wr_r;
      mem_g[pal_wr_idx] <= pal_wr_g;
      mem_b[pal_wr_idx] <= pal_wr_b;
    end
  end

  always_ff @(posedge RESET) begin   // One cycle read latency
    pal_r <= mem_r[pal_rd_idx];
    pal_g <= mem_g[pal_rd_idx];
    pal_b <= mem_b[pal_rd_idx];
  end

endmodule

// File: design/vdp_palette_loader.sv
// ------------------------------
// Palette byte pair assembly and
// auto-incrementing palette index
// ------------------------------
`timescale 1ns/1ps

module vdp_palette_loader #(
  parameter int PAL_ENTRIES = 16
) (
  input  logic                           RESET,     // Clock
  input  logic                           CLK21M,    // Async reset
  input  logic                           acc_wr,
  input  vdp_pkg::port_sel_t             acc_port,
  input  vdp_pkg::cpu_byte_t             acc_data,
  input  logic                           pal_idx_load,
  input  vdp_pkg::cpu_byte_t             reg_data,  // R16 value
  output logic                           pal_we,
  output logic [$clog2(PAL_ENTRIES)-1:0] pal_wr_idx,
  output vdp_pkg::pal_chan_t             pal_wr_r, pal_wr_g, pal_wr_b
);
  import vdp_pkg::*;

  localparam int IDX_W = $clog2(PAL_ENTRIES);

  logic [IDX_W-1:0] pal_idx;    // Next entry to write
  logic             have_rb;    // Red/blue byte already in
  cpu_byte_t        rb_byte;
  logic             p2_wr;

  assign p2_wr = acc_wr && (acc_port == PORT_PALETTE);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      pal_idx <= '0;
      have_rb <= 1'b0;
      pal_we  <= 1'b0;
    end else begin
      pal_we <= p2_wr && have_rb;
      if (pal_idx_load) begin
        pal_idx <= reg_data[IDX_W-1:0];
        have_rb <= 1'b0;                  // Restart the pair
      end else if (p2_wr) begin
        have_rb <= !have_rb;
        if (have_rb) pal_idx <= (pal_idx == IDX_W'(PAL_ENTRIES - 1)) ? '0 : pal_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge RESET) begin
    if (p2_wr && !have_rb) rb_byte <= acc_data;
    if (p2_wr && have_rb) begin
      pal_wr_idx <= pal_idx;
      pal_wr_r   <= rb_byte[6:4];
      pal_wr_b   <= rb_byte[2:0];
      pal_wr_g   <= acc_data[2:0];        // Green from second byte
    end
  end

endmodule

// File: design/vdp_vram_access.sv
// ------------------------------
// VRAM address and write data latches,
// single-cycle access strobes
// ------------------------------
`timescale 1ns/1ps

module vdp_vram_access #(
  parameter int VRAM_ADDR_W = 17
) (
  input  logic                   RESET,       // Clock
  input  logic                   CLK21M,      // Async reset
  input  logic                   acc_wr, acc_rd,
  input  vdp_pkg::port_sel_t     acc_port,
  input  vdp_pkg::cpu_byte_t     acc_data,
  input  logic                   p1_addr_set, p1_addr_read,
  input  logic [13:0]            p1_addr,
  input  logic                   reg_wr,
  input  vdp_pkg::reg_num_t      reg_num,
  input  vdp_pkg::cpu_byte_t     reg_data,
  output logic [VRAM_ADDR_W-1:0] vram_addr,
  output vdp_pkg::cpu_byte_t     vram_wdata,
  output logic                   vram_addr_set, vram_wr, vram_rd
);
  import vdp_pkg::*;

  logic r14_wr;        // Upper address bits
  logic p0_wr;

  assign r14_wr = reg_wr && (reg_num == 6'd14);
  assign p0_wr  = acc_wr && (acc_port == PORT_VRAM);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      vram_addr <= '0;
      {vram_addr_set, vram_wr, vram_rd} <= '0;
    end else begin
      vram_wr       <= p0_wr;
      vram_rd       <= (acc_rd && (acc_port == PORT_VRAM)) || p1_addr_read; // Read or read-ahead
      vram_addr_set <= p1_addr_set || r14_wr;
      if (p1_addr_set) vram_addr[13:0] <= p1_addr;
      if (r14_wr) vram_addr[VRAM_ADDR_W-1:14] <= reg_data[VRAM_ADDR_W-15:0];
    end
  end

  always_ff @(posedge RESET) begin
    if (p0_wr) vram_wdata <= acc_data;   // Byte to write
  end

endmodule

// File: design/vdp_status_read.sv
// ------------------------------
// Read data for ports 0 and 1,
// interrupt clear pulses
// ------------------------------
`timescale 1ns/1ps

module vdp_status_read (
  input  logic                 RESET,        // Clock
  input  logic                 CLK21M,       // Async reset
  input  logic                 acc_rd,
  input  vdp_pkg::port_sel_t   acc_port,
  input  vdp_pkg::status_num_t status_num,
  input  logic                 vsync_int, hsync_int, field,
  input  logic [6:0]           sprite_status,
  input  vdp_pkg::cpu_byte_t   vram_rd_data,
  input  logic                 reg_wr,
  input  vdp_pkg::reg_num_t    reg_num,
  input  vdp_pkg::cpu_byte_t   reg_data,
  output vdp_pkg::cpu_byte_t   dat_r,        // Held until the next read
  output logic                 clr_vsync_int, clr_hsync_int
);
  import vdp_pkg::*;

  cpu_byte_t status_byte;
  logic      p1_rd;

  assign p1_rd = acc_rd && (acc_port == PORT_CTRL);

  always_comb begin
    case (status_num)
      4'd0:    status_byte = {vsync_int, sprite_status};        // S#0
      4'd1:    status_byte = {2'b00, VDP_ID, hsync_int};        // S#1
      4'd2:    status_byte = {6'b000011, field, 1'b0};          // S#2
      default: status_byte = STATUS_FILL;
    endcase
  end

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dat_r         <= '0;
      clr_vsync_int <= 1'b0;
      clr_hsync_int <= 1'b0;
    end else begin
      if (acc_rd) dat_r <= (acc_port == PORT_VRAM) ? vram_rd_data :
                           (acc_port == PORT_CTRL) ? status_byte : STATUS_FILL;
      clr_vsync_int <= p1_rd && (status_num == 4'd0);
      // S#1 read, R19 write, or R0 write with bit 4 set
      clr_hsync_int <= (p1_rd && (status_num == 4'd1)) ||
                       (reg_wr && ((reg_num == 6'd19) || ((reg_num == 6'd0) && reg_data[4])));
    end
  end

endmodule

// File: design/vdp_ctrl_regs.sv
// ------------------------------
// Control register file, mode bits shadowed
// until hsync, one-hot screen mode decode
// ------------------------------
`timescale 1ns/1ps

module vdp_ctrl_regs (
  input  logic                  RESET,       // Clock
  input  logic                  CLK21M,      // Async reset
  input  logic                  hsync,       // Shadow copy pulse
  input  logic                  reg_wr,
  input  vdp_pkg::reg_num_t     reg_num,
  input  vdp_pkg::cpu_byte_t    reg_data,
  output vdp_pkg::status_num_t  status_num,  // R15
  output logic                  pal_idx_load,
  output logic                  disp_on, hsync_int_en, vsync_int_en,
  output logic                  sp_size, sp_zoom, blink_clks,
  output logic [6:0]            name_base,
  output vdp_pkg::cpu_byte_t    frame_col,
  output logic                  sp_off, col0_on, pal_mode, interlace, y_dots,
  output vdp_pkg::cpu_byte_t    hsync_int_line, vstart_line,
  output logic                  yae, yjk, msk, sp_mode2,
  output logic [2:0]            h_scroll_fine,
  output logic                  mode_text1, mode_text2, mode_multi,
  output logic                  mode_graphic1, mode_graphic2, mode_graphic3, mode_graphic4,
  output logic                  mode_graphic5, mode_graphic6, mode_graphic7, mode_high_res
);
  import vdp_pkg::*;

  logic [3:1] r0_mode;       // Written values, not yet visible
  logic [4:3] r1_mode;
  logic       r1_disp_on, r25_sp2;
  disp_mode_t disp_mode;     // Active mode after hsync

  assign pal_idx_load = reg_wr && (reg_num == 6'd16);  // R16 palette index

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      {r0_mode, r1_mode, r1_disp_on, r25_sp2} <= '0;
      {hsync_int_en, vsync_int_en, sp_size, sp_zoom, blink_clks} <= '0;
      {sp_off, col0_on, pal_mode, interlace, y_dots, yae, yjk, msk} <= '0;
      {name_base, frame_col, status_num, hsync_int_line, vstart_line, h_scroll_fine} <= '0;
      {disp_mode, disp_on, sp_mode2} <= '0;
    end else begin
      if (reg_wr) begin
        case (reg_num)
          6'd0:  {hsync_int_en, r0_mode} <= reg_data[4:1];
          6'd1:  begin
            {r1_disp_on, vsync_int_en, r1_mode} <= reg_data[6:3];
            {blink_clks, sp_size, sp_zoom}      <= reg_data[2:0];
          end
          6'd2:  name_base <= reg_data[6:0];        // Name table base
          6'd7:  frame_col <= reg_data;             // Text / backdrop colour
          6'd8:  {col0_on, sp_off} <= {reg_data[5], reg_data[1]};
          6'd9:  {y_dots, interlace, pal_mode} <= {reg_data[7], reg_data[3], reg_data[1]};
          6'd15: status_num <= reg_data[3:0];
          6'd19: hsync_int_line <= reg_data;
          6'd23: vstart_line <= reg_data;           // Vertical scroll
          6'd25: {yae, yjk, msk, r25_sp2} <= {reg_data[4:3], reg_data[1:0]};
          6'd27: h_scroll_fine <= reg_data[2:0];
          default: ;                                // R14, R16, R17 handled elsewhere
        endcase
      end
      if (hsync) begin                              // Mode change takes effect per line
        disp_mode <= {r0_mode, r1_mode[3], r1_mode[4]};
        disp_on   <= r1_disp_on;
        sp_mode2  <= r25_sp2;
      end
    end
  end

  // ------------------------------
  // Screen mode decode
  // ------------------------------
  assign mode_graphic1 = (disp_mode == 5'b00000);
  assign mode_text1    = (disp_mode == 5'b00001);
  assign mode_multi    = (disp_mode == 5'b00010);
  assign mode_graphic2 = (disp_mode == 5'b00100);
  assign mode_graphic3 = (disp_mode == 5'b01000);
  assign mode_text2    = (disp_mode == 5'b01001);   // 80 columns
  assign mode_graphic4 = (disp_mode == 5'b01100);
  assign mode_graphic5 = (disp_mode == 5'b10000);
  assign mode_graphic6 = (disp_mode == 5'b10100);
  assign mode_graphic7 = (disp_mode == 5'b11100);
  assign mode_high_res = (disp_mode[4:3] == 2'b10) && (disp_mode[1:0] == 2'b00); // 512 dots
endmodule

// File: design/vdp_cpu_port_ctrl.sv
// ------------------------------
// Wishbone classic slave for the four VDP ports,
// port-1 byte pair sequencer and R17 pointer
// ------------------------------
`timescale 1ns/1ps

module vdp_cpu_port_ctrl (
  input  logic               RESET,       // Clock
  input  logic               CLK21M,      // Async reset
  input  logic               cyc, stb, we,
  input  vdp_pkg::port_sel_t adr,
  input  vdp_pkg::cpu_byte_t dat_w,
  output logic               ack,
  output logic               acc_wr, acc_rd,
  output vdp_pkg::port_sel_t acc_port,
  output vdp_pkg::cpu_byte_t acc_data,
  output logic               p1_addr_set, p1_addr_read,
  output logic [13:0]        p1_addr,     // {second[5:0], first}
  output logic               reg_wr,
  output vdp_pkg::reg_num_t  reg_num,
  output vdp_pkg::cpu_byte_t reg_data
);
  import vdp_pkg::*;

  p1_state_e p1_state;
  cpu_byte_t p1_first;       // Buffered first byte of a port-1 pair
  reg_num_t  r17_ptr;        // Indirect register pointer
  logic      r17_auto_inc;
  logic      accept, p1_second, p3_wr;

  // Accept when idle, ack answers one cycle later
  assign accept   = cyc && stb && !ack;
  assign acc_wr   = accept && we;
  assign acc_rd   = accept && !we;
  assign acc_port = adr;
  assign acc_data = dat_w;

  // Second byte of a pair, bits 7..6 select the action
  assign p1_second    = acc_wr && (acc_port == PORT_CTRL) && (p1_state == P1_SECOND);
  assign p1_addr_set  = p1_second && !acc_data[7];   // 00 or 01
  assign p1_addr_read = p1_addr_set && !acc_data[6]; // 00 reads ahead
  assign p1_addr      = {acc_data[5:0], p1_first};
  assign p3_wr        = acc_wr && (acc_port == PORT_INDIRECT);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ack          <= 1'b0;
      reg_wr       <= 1'b0;
      p1_state     <= P1_FIRST;
      r17_ptr      <= '0;
      r17_auto_inc <= 1'b0;
    end else begin
      ack    <= accept;
      reg_wr <= (p1_second && acc_data[7]) || (p3_wr && (r17_ptr != REG_R17_NUM));
      if (acc_rd && (acc_port == PORT_CTRL)) begin
        p1_state <= P1_FIRST;                       // Status read restarts the pair
      end else if (acc_wr && (acc_port == PORT_CTRL)) begin
        p1_state <= (p1_state == P1_FIRST) ? P1_SECOND : P1_FIRST;
      end
      if (reg_wr && (reg_num == REG_R17_NUM)) begin
        r17_ptr      <= reg_data[5:0];
        r17_auto_inc <= !reg_data[7];               // Bit 7 set disables increment
      end else if (p3_wr && r17_auto_inc) begin
        r17_ptr <= r17_ptr + 1'b1;
      end
    end
  end

  // Pair buffer and register write payload
  always_ff @(posedge RESET) begin
    if (acc_wr && (acc_port == PORT_CTRL) && (p1_state == P1_FIRST)) p1_first <= acc_data;
    if (p1_second) begin
      reg_num  <= acc_data[5:0];
      reg_data <= p1_first;
    end else if (p3_wr) begin
      reg_num  <= r17_ptr;
      reg_data <= acc_data;
    end
  end

endmodule

// File: design/vdp_register_top.sv
// ------------------------------
// VDP register block top level
// Port controller, control registers, status read,
// VRAM access latches and palette
// ------------------------------
`timescale 1ns/1ps

module vdp_register_top #(
  parameter int PAL_ENTRIES = 16,
  parameter int VRAM_ADDR_W = 17
) (
  input  logic                  RESET,          // Clock
  input  logic                  CLK21M,         // Async reset, active high
  input  logic                  cyc, stb, we,
  input  vdp_pkg::port_sel_t    adr,
  input  vdp_pkg::cpu_byte_t    dat_w,
  output vdp_pkg::cpu_byte_t    dat_r,
  output logic                  ack,
  input  logic                  hsync, field, vsync_int, hsync_int,
  input  logic [6:0]            sprite_status,  // S#0 bits 6..0
  input  vdp_pkg::cpu_byte_t    vram_rd_data,
  output vdp_pkg::vram_addr_t   vram_addr,
  output vdp_pkg::cpu_byte_t    vram_wdata,
  output logic                  vram_addr_set, vram_wr, vram_rd,
  input  logic [3:0]            pal_rd_idx,
  output vdp_pkg::pal_chan_t    pal_r, pal_g, pal_b,
  output logic                  clr_vsync_int, clr_hsync_int,
  output logic                  disp_on, hsync_int_en, vsync_int_en,
  output logic                  sp_size, sp_zoom, blink_clks,
  output logic [6:0]            name_base,
  output vdp_pkg::cpu_byte_t    frame_col,
  output logic                  sp_off, col0_on, pal_mode, interlace, y_dots,
  output vdp_pkg::cpu_byte_t    hsync_int_line, vstart_line,
  output logic                  yae, yjk, msk, sp_mode2,
  output logic [2:0]            h_scroll_fine,
  output logic                  mode_text1, mode_text2, mode_multi,
  output logic                  mode_graphic1, mode_graphic2, mode_graphic3, mode_graphic4,
  output logic                  mode_graphic5, mode_graphic6, mode_graphic7, mode_high_res
);
  import vdp_pkg::*;

  logic        acc_wr, acc_rd;          // One-cycle request strobes
  port_sel_t   acc_port;
  cpu_byte_t   acc_data;
  logic        p1_addr_set, p1_addr_read;
  logic [13:0] p1_addr;
  logic        reg_wr;                  // Register write strobe
  reg_num_t    reg_num;
  cpu_byte_t   reg_data;
  status_num_t status_num;
  logic        pal_idx_load, pal_we;
  logic [$clog2(PAL_ENTRIES)-1:0] pal_wr_idx;
  pal_chan_t   pal_wr_r, pal_wr_g, pal_wr_b;

  vdp_cpu_port_ctrl u_port_ctrl (
    .RESET, .CLK21M, .cyc, .stb, .we, .adr, .dat_w, .ack,
    .acc_wr, .acc_rd, .acc_port, .acc_data,
    .p1_addr_set, .p1_addr_read, .p1_addr, .reg_wr, .reg_num, .reg_data
  );

  vdp_ctrl_regs u_ctrl_regs (
    .RESET, .CLK21M, .hsync, .reg_wr, .reg_num, .reg_data, .status_num, .pal_idx_load,
    .disp_on, .hsync_int_en, .vsync_int_en, .sp_size, .sp_zoom, .blink_clks,
    .name_base, .frame_col, .sp_off, .col0_on, .pal_mode, .interlace, .y_dots,
    .hsync_int_line, .vstart_line, .yae, .yjk, .msk, .sp_mode2, .h_scroll_fine,
    .mode_text1, .mode_text2, .mode_multi, .mode_graphic1, .mode_graphic2,
    .mode_graphic3, .mode_graphic4, .mode_graphic5, .mode_graphic6,
    .mode_graphic7, .mode_high_res
  );

  vdp_status_read u_status_read (
    .RESET, .CLK21M, .acc_rd, .acc_port, .status_num, .vsync_int, .hsync_int,
    .field, .sprite_status, .vram_rd_data, .reg_wr, .reg_num, .reg_data,
    .dat_r, .clr_vsync_int, .clr_hsync_int
  );

  vdp_vram_access #(.VRAM_ADDR_W(VRAM_ADDR_W)) u_vram_access (
    .RESET, .CLK21M, .acc_wr, .acc_rd, .acc_port, .acc_data,
    .p1_addr_set, .p1_addr_read, .p1_addr, .reg_wr, .reg_num, .reg_data,
    .vram_addr, .vram_wdata, .vram_addr_set, .vram_wr, .vram_rd
  );

  vdp_palette_loader #(.PAL_ENTRIES(PAL_ENTRIES)) u_palette_loader (
    .RESET, .CLK21M, .acc_wr, .acc_port, .acc_data, .pal_idx_load, .reg_data,
    .pal_we, .pal_wr_idx, .pal_wr_r, .pal_wr_g, .pal_wr_b
  );

  vdp_palette_ram #(.PAL_ENTRIES(PAL_ENTRIES)) u_palette_ram (
    .RESET, .CLK21M, .pal_we, .pal_wr_idx, .pal_wr_r, .pal_wr_g, .pal_wr_b,
    .pal_rd_idx, .pal_r, .pal_g, .pal_b
  );

endmodule

// File: sim/tb_clock_gen.sv
// ------------------------------
// Testbench clock and reset source
// ------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic RESET,    // Clock
  output logic CLK21M    // Reset, active high
);
  initial RESET = 1'b0;
  always #(PERIOD_NS / 2) RESET = ~RESET;

  initial begin
    CLK21M = 1'b1;
    repeat (RESET_CYCLES) @(posedge RESET);
    #2 CLK21M = 1'b0;    // Released with the other inputs
  end
endmodule

// File: sim/vdp_register_sva.sv
// ------------------------------
// Wishbone handshake and reset-quiet rules
// for the port controller, with its bind
// ------------------------------
`timescale 1ns/1ps

module vdp_register_sva (
  input logic RESET,          // Clock
  input logic CLK21M,         // Reset
  input logic cyc, stb, ack,
  input logic acc_wr, acc_rd, reg_wr, p1_addr_set
);
  int fail_count = 0;         // Read by the testbench at the end

  // Accepted request gets ack on the next edge
  ack_after_accept: assert property (@(posedge RESET) disable iff (CLK21M)
    (cyc && stb && !ack) |=> ack)
    else begin
      $error("ack missing one cycle after an accepted request");
      fail_count++;
    end

  // Single-cycle ack
  ack_one_cycle: assert property (@(posedge RESET) disable iff (CLK21M) ack |=> !ack)
    else begin
      $error("ack held for two cycles");
      fail_count++;
    end

  // Everything quiet while reset is applied
  quiet_in_reset: assert property (@(posedge RESET)
    CLK21M |-> !(ack || acc_wr || acc_rd || reg_wr || p1_addr_set))
    else begin
      $error("ack or a strobe active during reset");
      fail_count++;
    end
endmodule

bind vdp_cpu_port_ctrl vdp_register_sva sva0 (.*);

// File: sim/tb_vdp_register.sv
// ------------------------------
// Testbench for the VDP register block
// Bus transfers, checks, watchdog, summary
// ------------------------------
`timescale 1ns/1ps

module tb_vdp_register;
  import vdp_pkg::*;

  localparam int ACK_LIMIT   = 8;       // Cycles to wait for ack
  localparam int WATCHDOG_NS = 20000;   // ~110 cycles of tests plus wide margin

  logic RESET, CLK21M;
  logic cyc, stb, we, hsync, field, vsync_int, hsync_int;
  port_sel_t adr;
  cpu_byte_t dat_w, dat_r, vram_rd_data, vram_wdata, frame_col, hsync_int_line, vstart_line;
  logic ack, vram_addr_set, vram_wr, vram_rd, clr_vsync_int, clr_hsync_int;
  logic [6:0] sprite_status, name_base;
  vram_addr_t vram_addr;
  logic [3:0] pal_rd_idx;
  pal_chan_t pal_r, pal_g, pal_b;
  logic disp_on, hsync_int_en, vsync_int_en, sp_size, sp_zoom, blink_clks;
  logic sp_off, col0_on, pal_mode, interlace, y_dots, yae, yjk, msk, sp_mode2;
  logic [2:0] h_scroll_fine;
  logic mode_text1, mode_text2, mode_multi, mode_graphic1, mode_graphic2, mode_graphic3;
  logic mode_graphic4, mode_graphic5, mode_graphic6, mode_graphic7, mode_high_res;

  int errors = 0;
  logic [5:0] strb_ack, strb_next;      // Strobes in the ack cycle and the one after
  cpu_byte_t  rd, d, lo, hi, b1, b2;
  logic [6:0] ss;
  pal_chan_t  exp_r [4], exp_g [4], exp_b [4];

  tb_clock_gen clk_gen0 (.RESET(RESET), .CLK21M(CLK21M));
  vdp_register_top dut0 (.*);

  // {vram_wr, vram_rd, vram_addr_set, clr_vsync_int, clr_hsync_int, pal_we}
  function automatic logic [5:0] strobes();
    return {vram_wr, vram_rd, vram_addr_set, clr_vsync_int, clr_hsync_int,
            dut0.u_palette_loader.pal_we};
  endfunction

  function automatic logic [10:0] mode_flags();
    return {mode_text1, mode_text2, mode_multi, mode_graphic1, mode_graphic2, mode_graphic3,
            mode_graphic4, mode_graphic5, mode_graphic6, mode_graphic7, mode_high_res};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // One Wishbone transfer, entered and left 2 ns after a rising edge
  task automatic bus_xfer(input logic wr, input port_sel_t port, input cpu_byte_t data);
    int waited;
    waited = 0;
    cyc = 1'b1;
    stb = 1'b1;
    we = wr;
    adr = port;
    dat_w = data;
    @(posedge RESET);
    #1;
    while (!ack && waited < ACK_LIMIT) begin
      @(posedge RESET);
      #1;
      waited++;
    end
    if (!ack) begin
      $display("No ack from the DUT on port %0d within %0d cycles", port, ACK_LIMIT);
      errors++;
    end
    rd = dat_r;                          // Read data valid with ack
    strb_ack = strobes();
    #1;
    {cyc, stb, we} = 3'b000;
    @(posedge RESET);
    #1 strb_next = strobes();
    #1;
  endtask

  task automatic write_reg(input int num, input cpu_byte_t val);
    bus_xfer(1'b1, PORT_CTRL, val);
    bus_xfer(1'b1, PORT_CTRL, 8'h80 | cpu_byte_t'(num));   // 1x selects a register write
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(30));
    {cyc, stb, we, hsync, field, vsync_int, hsync_int} = '0;
    {adr, dat_w, vram_rd_data, sprite_status, pal_rd_idx} = '0;
    @(negedge CLK21M);

    // ------------------------------
    // Reset state, port 0
    // ------------------------------
    check("ack", 0, ack);
    check("strobes", 0, strobes());
    d = 8'($urandom);
    bus_xfer(1'b1, PORT_VRAM, d);
    check("strobes on port-0 write", 6'b100000, strb_ack);
    check("vram_wdata", d, vram_wdata);
    vram_rd_data = 8'($urandom);
    bus_xfer(1'b0, PORT_VRAM, 8'h00);
    check("strobes on port-0 read", 6'b010000, strb_ack);
    check("dat_r from VRAM", vram_rd_data, rd);

    // Address pair, then upper bits through R14
    lo = 8'($urandom);
    hi = 8'h40 | (8'($urandom) & 8'h3F);
    bus_xfer(1'b1, PORT_CTRL, lo);
    bus_xfer(1'b1, PORT_CTRL, hi);
    check("strobes on address set", 6'b001000, strb_ack);
    check("vram_addr", {3'b000, hi[5:0], lo}, vram_addr);
    write_reg(14, 8'h05);
    check("strobes after R14 write", 6'b001000, strb_next);
    check("vram_addr", {3'b101, hi[5:0], lo}, vram_addr);

    // ------------------------------
    // Direct, indirect and mode registers
    // ------------------------------
    d = 8'($urandom);
    write_reg(7, d);
    check("frame_col", d, frame_col);
    write_reg(17, 8'd18);                // Pointer at R18, auto-increment on
    bus_xfer(1'b1, PORT_INDIRECT, 8'hA5); // R18 is not kept
    d = 8'($urandom);
    bus_xfer(1'b1, PORT_INDIRECT, d);    // Lands in R19
    check("hsync_int_line", d, hsync_int_line);
    check("strobes after R19 write", 6'b000010, strb_next);
    check("mode flags at reset", 11'b00010000000, mode_flags());   // Graphic 1
    write_reg(0, 8'h14);                 // IE1, M4
    check("strobes after R0 write", 6'b000010, strb_next);         // Bit 4 clears hsync int
    write_reg(1, 8'h76);                 // Display on, IE0, M1, blink clocks, sprite size
    write_reg(25, 8'h13);                // YAE, MSK, sprite mode 2
    check("mode flags before hsync", 11'b00010000000, mode_flags());
    check("disp_on before hsync", 0, disp_on);
    check("sp_mode2 before hsync", 0, sp_mode2);
    hsync = 1'b1;
    @(posedge RESET);
    #2 hsync = 1'b0;
    check("mode flags after hsync", 11'b01000000000, mode_flags());  // Text 2
    check("disp_on after hsync", 1, disp_on);
    check("sp_mode2 after hsync", 1, sp_mode2);
    check("hsync_int_en", 1, hsync_int_en);
    check("{vsync_int_en, blink_clks, sp_size, sp_zoom}", 4'b1110,
          {vsync_int_en, blink_clks, sp_size, sp_zoom});
    check("{yae, yjk, msk}", 3'b101, {yae, yjk, msk});

    // Remaining plain registers
    d = 8'($urandom);
    write_reg(2, d);
    check("name_base", d[6:0], name_base);
    d = 8'($urandom);
    write_reg(8, d);
    check("{col0_on, sp_off}", {d[5], d[1]}, {col0_on, sp_off});   // TP, SPD
    d = 8'($urandom);
    write_reg(9, d);
    check("{y_dots, interlace, pal_mode}", {d[7], d[3], d[1]},
          {y_dots, interlace, pal_mode});
    d = 8'($urandom);
    write_reg(23, d);
    check("vstart_line", d, vstart_line);
    d = 8'($urandom);
    write_reg(27, d);
    check("h_scroll_fine", d[2:0], h_scroll_fine);

    // ------------------------------
    // Status registers
    // ------------------------------
    ss = 7'($urandom);
    {sprite_status, vsync_int, hsync_int, field} = {ss, 3'b111};
    write_reg(15, 8'd0);
    bus_xfer(1'b0, PORT_CTRL, 8'h00);
    check("S#0", {1'b1, ss}, rd);
    check("strobes on S#0 read", 6'b000100, strb_ack);
    write_reg(15, 8'd1);
    bus_xfer(1'b0, PORT_CTRL, 8'h00);
    check("S#1", {2'b00, VDP_ID, 1'b1}, rd);
    check("strobes on S#1 read", 6'b000010, strb_ack);
    write_reg(15, 8'd2);
    bus_xfer(1'b0, PORT_CTRL, 8'h00);
    check("S#2", 8'h0C | 8'h02, rd);
    write_reg(15, 8'd5);
    bus_xfer(1'b0, PORT_CTRL, 8'h00);
    check("S#5", STATUS_FILL, rd);

    // ------------------------------
    // Palette pairs from index 14, wrapping past 15
    // ------------------------------
    write_reg(16, 8'd14);
    for (int i = 0; i < 4; i++) begin
      b1 = 8'($urandom);
      b2 = 8'($urandom);
      bus_xfer(1'b1, PORT_PALETTE, b1);
      bus_xfer(1'b1, PORT_PALETTE, b2);
      check("strobes on palette pair", 6'b000001, strb_ack);
      {exp_r[i], exp_b[i], exp_g[i]} = {b1[6:4], b1[2:0], b2[2:0]};
    end
    for (int i = 0; i < 4; i++) begin
      pal_rd_idx = 4'(14 + i);
      @(posedge RESET);
      #1;
      check("pal_r", exp_r[i], pal_r);
      check("pal_g", exp_g[i], pal_g);
      check("pal_b", exp_b[i], pal_b);
      #1;
    end

    $display("Check errors: %0d, assertion failures: %0d",
             errors, dut0.u_port_ctrl.sva0.fail_count);
    if (errors == 0 && dut0.u_port_ctrl.sva0.fail_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end
endmodule

// File: project.f
design/vdp_pkg.sv
design/vdp_palette_ram.sv
design/vdp_palette_loader.sv
design/vdp_vram_access.sv
design/vdp_status_read.sv
design/vdp_ctrl_regs.sv
design/vdp_cpu_port_ctrl.sv
design/vdp_register_top.sv
sim/tb_clock_gen.sv
sim/vdp_register_sva.sv
sim/tb_vdp_register.sv
